// ==== logic/gb_params.svh ====
/*
 * system bus fabric parameters
 * bus widths, memory sizes and the fixed FFxx register offsets
 */
`ifndef GB_PARAMS_SVH
`define GB_PARAMS_SVH

// ----------------------------------------------------
// widths
`define GB_ADDR_W 16 // cpu address bus
`define GB_DATA_W 8 // cpu data byte
`define GB_WRAM_AW 15 // 32 KiB work ram, 8 banks of 4 KiB
`define GB_HRAM_AW 7 // high ram at ff80-fffe
`define GB_BOOT_AW 12 // 4 KiB boot store
`define GB_IRQ_N 5 // vblank, lcdc, timer, serial, joypad

// open bus pull-up time in clk_sys cycles
`define GB_OPEN_BUS_DECAY 4

// ----------------------------------------------------
// io register offsets inside page ff
`define GB_IO_JOY 8'h00
`define GB_IO_IF 8'h0f
`define GB_IO_IE 8'hff
`define GB_IO_SVBK 8'h70
`define GB_IO_BOOT_OFF 8'h50

`endif

// ==== logic/gb_bus_pkg.sv ====
/*
 * cpu bus types
 * address word with its two decodes, the cpu request bundle
 * and the region the address decoder selects
 */
`include "gb_params.svh"

package gb_bus_pkg;

	// page/offset view, used for the ffxx registers
	typedef struct packed {
		logic [7:0] page; // high byte
		logic [7:0] offs; // low byte
	} gb_addr_po_t;

	// one address word, read flat for memory ranges or split for io
	typedef union packed {
		logic [`GB_ADDR_W-1:0] flat;
		gb_addr_po_t po;
	} gb_addr_u;

	// everything the cpu drives in one cycle
	typedef struct packed {
		gb_addr_u addr;
		logic [`GB_DATA_W-1:0] wdata;
		logic rd_n; // read strobe, active low
		logic wr_n; // write strobe, active low
		logic ack; // interrupt acknowledge cycle
	} gb_cpu_req_t;

	typedef enum logic [3:0] {
		rgn_rom = 4'd0, rgn_cram = 4'd1, rgn_wram = 4'd2, rgn_hram = 4'd3,
		rgn_joy = 4'd4, rgn_irq_if = 4'd5, rgn_irq_ie = 4'd6, rgn_svbk = 4'd7,
		rgn_boot_off = 4'd8, rgn_unmapped = 4'd9
	} gb_region_t;

endpackage

// ==== logic/gb_irq_pkg.sv ====
/*
 * interrupt types
 * event lines from the dropped peripherals and the vector byte
 */
`include "gb_params.svh"

package gb_irq_pkg;

	// packed so that bit n matches IF bit n
	typedef struct packed {
		logic serial; // IF bit 3
		logic timer; // IF bit 2
		logic lcdc; // IF bit 1
		logic vblank; // IF bit 0
	} gb_irq_src_t;

	typedef logic [`GB_DATA_W-1:0] gb_irq_vec_t;

	localparam gb_irq_vec_t irq_vec_base = 8'h40; // vblank handler, 8 bytes apart
	localparam gb_irq_vec_t irq_vec_none = 8'h00; // nothing pending

endpackage

// ==== logic/gb_addr_decode.sv ====
/*
 * address decoder
 * maps a cpu address onto exactly one region of the memory map.
 * purely combinational, the boot overlay is handled elsewhere
 */
`timescale 1ns/1ns
`include "gb_params.svh"

module gb_addr_decode (
	input gb_bus_pkg::gb_addr_u addr_i,
	output gb_bus_pkg::gb_region_t region_o
);
	import gb_bus_pkg::*;

	// memory map
	//  0000-7fff  cartridge rom
	//  8000-9fff  video ram (not here, unmapped)
	//  a000-bfff  cartridge ram
	//  c000-dfff  work ram, e000-fdff echoes c000-ddff
	//  fe00-feff  oam (not here, unmapped)
	//  ff00-ff7f  io registers
	//  ff80-fffe  high ram, ffff is IE

	logic is_rom;
	logic is_cram;
	logic is_wram;
	logic is_io_page;

	assign is_rom = ~addr_i.flat[15]; // lower 32k
	assign is_cram = addr_i.flat[15:13] == 3'b101;
	assign is_wram = (addr_i.flat[15:14] == 2'b11) && ~&addr_i.flat[13:9]; // stops at fdff
	assign is_io_page = addr_i.po.page == 8'hff;

	always_comb begin
		region_o = rgn_unmapped; // vram, oam and unused io
		if (is_rom) begin
			region_o = rgn_rom;
		end else if (is_cram) begin
			region_o = rgn_cram;
		end else if (is_wram) begin
			region_o = rgn_wram;
		end else if (is_io_page) begin
			case (addr_i.po.offs)
				`GB_IO_JOY: region_o = rgn_joy;
				`GB_IO_IF: region_o = rgn_irq_if;
				`GB_IO_IE: region_o = rgn_irq_ie; // wins over hram
				`GB_IO_SVBK: region_o = rgn_svbk;
				`GB_IO_BOOT_OFF: region_o = rgn_boot_off;
				default: begin
					// ff80 and up is high ram
					if (addr_i.po.offs[7]) begin
						region_o = rgn_hram;
					end
				end
			endcase
		end
	end

endmodule

// ==== logic/gb_irq_ctrl.sv ====
/*
 * interrupt controller
 * IF/IE registers, event edge capture, joypad falling edge,
 * acknowledge vector and clearing of the serviced flag
 */
`timescale 1ns/1ns
`include "gb_params.svh"

module gb_irq_ctrl (
	input logic clk_sys,
	input logic reset_ss,
	input gb_irq_pkg::gb_irq_src_t src_i,
	input logic [3:0] joy_din_i,
	input logic wr_stb_i,
	input logic sel_if_i,
	input logic sel_ie_i,
	input logic [`GB_DATA_W-1:0] wdata_i,
	input logic ack_i,
	output logic [`GB_IRQ_N-1:0] if_o,
	output logic [`GB_DATA_W-1:0] ie_o,
	output gb_irq_pkg::gb_irq_vec_t vec_o,
	output logic irq_n_o
);
	import gb_irq_pkg::*;

	logic [`GB_IRQ_N-1:0] if_q;
	logic [`GB_DATA_W-1:0] ie_q;
	gb_irq_src_t src_s1, src_s2; // event sample pipeline
	logic [3:0] joy_s1, joy_s2; // joypad sync stages
	logic ack_q;
	logic ack_fall;
	logic [`GB_IRQ_N-1:0] pend; // pending and enabled
	logic [`GB_IRQ_N-1:0] clr_mask; // lowest pending bit only
	logic [`GB_IRQ_N-1:0] set_mask;

	assign pend = if_q & ie_q[`GB_IRQ_N-1:0];
	assign ack_fall = ack_q & ~ack_i;
	// rising edge on an event line, falling edge on any joypad line
	assign set_mask = {|(~joy_s1 & joy_s2), src_s1 & ~src_s2};

	// ----------------------------------------------------
	// priority: bit 0 first. vector is 40 + 8 * index
	always_comb begin
		clr_mask = '0;
		vec_o = irq_vec_none;
		for (int i = `GB_IRQ_N-1; i >= 0; i--) begin
			if (pend[i]) begin // lower index overrides
				clr_mask = '0;
				clr_mask[i] = 1'b1;
				vec_o = gb_irq_vec_t'(irq_vec_base + (i << 3));
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_q <= '0;
			ie_q <= '0;
			src_s1 <= '0;
			src_s2 <= '0;
			joy_s1 <= '1; // lines idle high
			joy_s2 <= '1;
			ack_q <= 1'b0;
		end else begin
			src_s1 <= src_i;
			src_s2 <= src_s1;
			joy_s1 <= joy_din_i;
			joy_s2 <= joy_s1;
			ack_q <= ack_i;
			if (wr_stb_i && sel_if_i) begin
				if_q <= wdata_i[`GB_IRQ_N-1:0]; // cpu write wins
			end else begin
				if_q <= (if_q | set_mask) & ~(ack_fall ? clr_mask : '0);
			end
			if (wr_stb_i && sel_ie_i) ie_q <= wdata_i;
		end
	end

	assign if_o = if_q;
	assign ie_o = ie_q;
	assign irq_n_o = ~|pend; // low while an enabled flag is set

	// an acknowledge clears no more than the one serviced flag
	a_one_clear_per_ack: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(ack_fall && !(wr_stb_i && sel_if_i)) |=> $onehot0($past(if_q) & ~if_q));

endmodule

// ==== logic/gb_work_ram.sv ====
/*
 * work ram and high ram
 * 32 KiB banked work ram with the svbk bank register and
 * the 127-byte high ram. one cycle synchronous read
 */
`timescale 1ns/1ns
`include "gb_params.svh"

module gb_work_ram (
	input logic clk_sys,
	input logic reset_ss,
	input logic is_gbc_i,
	input logic [15:0] addr_i,
	input logic sel_wram_i,
	input logic sel_hram_i,
	input logic sel_svbk_i,
	input logic wr_stb_i,
	input logic [`GB_DATA_W-1:0] wdata_i,
	output logic [`GB_DATA_W-1:0] rdata_o,
	output logic [2:0] bank_o
);
	import gb_bus_pkg::*;

	logic [`GB_DATA_W-1:0] wram [0:(1 << `GB_WRAM_AW)-1];
	logic [`GB_DATA_W-1:0] hram [0:126]; // ff80-fffe
	gb_addr_u addr_u;
	logic [2:0] bank_q; // svbk, raw value
	logic [2:0] map_bank;
	logic [`GB_WRAM_AW-1:0] wram_addr;
	logic [`GB_HRAM_AW-1:0] hram_addr;
	logic [`GB_DATA_W-1:0] wram_q, hram_q;

	assign addr_u = addr_i;
	assign map_bank = !is_gbc_i ? 3'd1 : (bank_q == 3'd0) ? 3'd1 : bank_q; // 0 -> 1
	// c000 window is bank 0, d000 window is the mapped bank. echo shares bits 12:0
	assign wram_addr = addr_u.flat[12] ? {map_bank, addr_u.flat[11:0]} : {3'd0, addr_u.flat[11:0]};
	assign hram_addr = addr_u.po.offs[`GB_HRAM_AW-1:0];

	always_ff @(posedge clk_sys) begin
		if (reset_ss) bank_q <= 3'd0;
		else if (is_gbc_i && sel_svbk_i && wr_stb_i) bank_q <= wdata_i[2:0];
	end

	always_ff @(posedge clk_sys) begin
		if (wr_stb_i && sel_wram_i) wram[wram_addr] <= wdata_i;
		if (wr_stb_i && sel_hram_i) hram[hram_addr] <= wdata_i;
		wram_q <= wram[wram_addr]; // read before write
		hram_q <= hram[hram_addr];
	end

	assign rdata_o = sel_hram_i ? hram_q : wram_q;
	assign bank_o = bank_q;

	a_upper_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(sel_wram_i && addr_u.flat[12]) |-> (wram_addr[`GB_WRAM_AW-1:12] != 3'd0));

endmodule

// ==== logic/gb_boot_overlay.sv ====
/*
 * boot rom overlay
 * 4 KiB boot store loaded through the download port. it covers
 * 0000-00ff, plus 0200-08ff on colour models, until ff50 is written
 */
`timescale 1ns/1ns
`include "gb_params.svh"

module gb_boot_overlay (
	input logic clk_sys,
	input logic reset_ss,
	input logic is_gbc_i,
	input logic [15:0] addr_i,
	input logic wr_stb_i,
	input logic sel_off_i,
	input logic dl_wr_i,
	input logic [`GB_BOOT_AW-1:0] dl_addr_i,
	input logic [`GB_DATA_W-1:0] dl_data_i,
	output logic boot_sel_o,
	output logic [`GB_DATA_W-1:0] rdata_o
);
	import gb_bus_pkg::*;

	logic [`GB_DATA_W-1:0] store [0:(1 << `GB_BOOT_AW)-1];
	gb_addr_u addr_u;
	logic boot_en_q; // overlay active
	logic in_window;

	assign addr_u = addr_i;
	// 0100-01ff is the cartridge header and always reads through
	assign in_window = (addr_u.po.page == 8'h00) ||
		(is_gbc_i && addr_u.po.page >= 8'h02 && addr_u.po.page <= 8'h08);
	assign boot_sel_o = boot_en_q & in_window;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) boot_en_q <= 1'b1;
		else if (wr_stb_i && sel_off_i) boot_en_q <= 1'b0; // any value disables
	end

	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) store[dl_addr_i] <= dl_data_i;
		rdata_o <= store[addr_u.flat[`GB_BOOT_AW-1:0]];
	end

	// only reset brings the overlay back
	a_stays_off: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!boot_en_q |=> !boot_en_q);

endmodule

// ==== logic/gb_cart_bus.sv ====
/*
 * cartridge bus
 * read and write strobes, A15 and nCS, and the open-bus
 * latch that decays to ff when nothing drives the bus
 */
`timescale 1ns/1ns
`include "gb_params.svh"

module gb_cart_bus (
	input logic clk_sys,
	input logic reset_ss,
	input logic [15:0] addr_i,
	input logic rd_n_i,
	input logic wr_stb_i,
	input logic sel_rom_i,
	input logic sel_cram_i,
	input logic boot_sel_i,
	input logic [`GB_DATA_W-1:0] cart_do_i,
	input logic cart_oe_i,
	output logic [14:0] ext_addr_o,
	output logic ext_a15_o,
	output logic cart_rd_o,
	output logic cart_wr_o,
	output logic ncs_o,
	output logic [`GB_DATA_W-1:0] rdata_o
);
	import gb_bus_pkg::*;

	localparam logic [2:0] ob_decay = 3'(`GB_OPEN_BUS_DECAY);

	gb_addr_u addr_u;
	logic rom_act; // rom access not hidden by the overlay
	logic cart_sel;
	logic cart_drv; // cartridge is driving the bus
	logic [2:0] ob_cnt; // cycles since last drive
	logic [`GB_DATA_W-1:0] ob_data; // last byte seen on the bus
	logic [`GB_DATA_W-1:0] ext_di;

	assign addr_u = addr_i;
	assign rom_act = sel_rom_i & ~boot_sel_i;
	assign cart_sel = rom_act | sel_cram_i;
	assign cart_drv = cart_sel & cart_oe_i;

	// rom is taken as is, cart ram falls back to open bus
	assign ext_di = rom_act ? cart_do_i : (sel_cram_i && cart_oe_i) ? cart_do_i : ob_data;

	// ----------------------------------------------------
	// open bus, slow pull-up to ff
	always_ff @(posedge clk_sys) begin
		if (reset_ss) ob_cnt <= 3'd0;
		else if (cart_drv) ob_cnt <= 3'd0;
		else if (!(&ob_cnt)) ob_cnt <= ob_cnt + 3'd1; // saturates
	end

	always_ff @(posedge clk_sys) begin
		if (!cart_drv && ob_cnt == ob_decay) ob_data <= 8'hff;
		else ob_data <= ext_di; // holds while undriven
	end

	// A15 stays high while the boot rom answers
	assign ext_a15_o = addr_u.flat[15] | boot_sel_i;
	assign ext_addr_o = addr_u.flat[14:0];
	assign ncs_o = ~sel_cram_i; // wram is internal
	assign cart_rd_o = cart_sel & ~rd_n_i;
	assign cart_wr_o = cart_sel & wr_stb_i;
	assign rdata_o = ext_di;

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!(cart_rd_o && cart_wr_o));

endmodule

// ==== logic/gb_sys_bus.sv ====
/*
 * system bus fabric top
 * write-edge detection, address decode fan-out, joypad select
 * register and the cpu read-data mux over all bus slaves
 */
`timescale 1ns/1ns
`include "gb_params.svh"

module gb_sys_bus (
	input logic clk_sys,
	input logic reset_ss,
	input logic is_gbc_i,
	input gb_bus_pkg::gb_cpu_req_t cpu_i,
	output logic [`GB_DATA_W-1:0] cpu_rdata_o,
	output logic irq_n_o,
	input gb_irq_pkg::gb_irq_src_t irq_src_i,
	input logic [3:0] joy_din_i,
	output logic [1:0] joy_p54_o,
	input logic dl_wr_i,
	input logic [`GB_BOOT_AW-1:0] dl_addr_i,
	input logic [`GB_DATA_W-1:0] dl_data_i,
	output logic [14:0] ext_addr_o,
	output logic ext_a15_o,
	output logic cart_rd_o,
	output logic cart_wr_o,
	input logic [`GB_DATA_W-1:0] cart_do_i,
	input logic cart_oe_i,
	output logic ncs_o
);
	import gb_bus_pkg::*;
	import gb_irq_pkg::*;

	gb_region_t region;
	logic wr_n_q, wr_stb;
	logic [1:0] p54_q; // joypad P14/P15 select
	logic boot_sel;
	logic [`GB_IRQ_N-1:0] if_q;
	logic [`GB_DATA_W-1:0] ie_q, wram_rdata, boot_rdata, cart_rdata;
	logic [2:0] bank;
	gb_irq_vec_t irq_vec;

	// ----------------------------------------------------
	// one write per cpu cycle, on the wr_n fall
	always_ff @(posedge clk_sys) begin
		if (reset_ss) wr_n_q <= 1'b1;
		else wr_n_q <= cpu_i.wr_n;
	end
	assign wr_stb = wr_n_q & ~cpu_i.wr_n;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) p54_q <= 2'b00;
		else if (wr_stb && region == rgn_joy) p54_q <= cpu_i.wdata[5:4];
	end
	assign joy_p54_o = p54_q;

	gb_addr_decode u_dec (.addr_i(cpu_i.addr), .region_o(region));

	gb_irq_ctrl u_irq (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .src_i(irq_src_i), .joy_din_i(joy_din_i),
		.wr_stb_i(wr_stb), .sel_if_i(region == rgn_irq_if), .sel_ie_i(region == rgn_irq_ie),
		.wdata_i(cpu_i.wdata), .ack_i(cpu_i.ack), .if_o(if_q), .ie_o(ie_q),
		.vec_o(irq_vec), .irq_n_o(irq_n_o)
	);

	gb_work_ram u_wram (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .is_gbc_i(is_gbc_i), .addr_i(cpu_i.addr.flat),
		.sel_wram_i(region == rgn_wram), .sel_hram_i(region == rgn_hram),
		.sel_svbk_i(region == rgn_svbk), .wr_stb_i(wr_stb), .wdata_i(cpu_i.wdata),
		.rdata_o(wram_rdata), .bank_o(bank)
	);

	gb_boot_overlay u_boot (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .is_gbc_i(is_gbc_i), .addr_i(cpu_i.addr.flat),
		.wr_stb_i(wr_stb), .sel_off_i(region == rgn_boot_off), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i), .boot_sel_o(boot_sel), .rdata_o(boot_rdata)
	);

	gb_cart_bus u_cart (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .addr_i(cpu_i.addr.flat), .rd_n_i(cpu_i.rd_n),
		.wr_stb_i(wr_stb), .sel_rom_i(region == rgn_rom), .sel_cram_i(region == rgn_cram),
		.boot_sel_i(boot_sel), .cart_do_i(cart_do_i), .cart_oe_i(cart_oe_i),
		.ext_addr_o(ext_addr_o), .ext_a15_o(ext_a15_o), .cart_rd_o(cart_rd_o),
		.cart_wr_o(cart_wr_o), .ncs_o(ncs_o), .rdata_o(cart_rdata)
	);

	// ----------------------------------------------------
	// read mux, highest priority first
	always_comb begin
		if (cpu_i.ack) cpu_rdata_o = irq_vec; // acknowledge cycle
		else if (region == rgn_irq_if) cpu_rdata_o = {3'b111, if_q};
		else if (boot_sel) cpu_rdata_o = boot_rdata; // shadows rom
		else if (region == rgn_wram || region == rgn_hram) cpu_rdata_o = wram_rdata;
		else if (region == rgn_rom || region == rgn_cram) cpu_rdata_o = cart_rdata;
		else if (region == rgn_joy) cpu_rdata_o = {2'b11, p54_q, joy_din_i};
		else if (region == rgn_irq_ie) cpu_rdata_o = ie_q;
		else if (region == rgn_svbk && is_gbc_i) cpu_rdata_o = {5'b11111, bank};
		else cpu_rdata_o = 8'hff; // unmapped, ff50 and svbk on dmg
	end

endmodule

// ==== verif/gb_sys_bus_tb.sv ====
/*
 * system bus fabric testbench
 * runs the operations listed in the test file against the bus top,
 * models a cartridge on the external bus and counts cart ram writes
 */
`timescale 1ns/1ns
`include "gb_params.svh"

module gb_sys_bus_tb;
	import gb_bus_pkg::*;
	import gb_irq_pkg::*;

	localparam int clk_half = 10; // 20 ns period
	localparam int drive_dly = 2; // inputs move 2 ns after the edge
	localparam int read_lat = 2; // edges until read data is valid
	localparam int wait_max = 32; // cycle limit of every wait loop

	logic clk_sys;
	logic reset_ss;
	logic is_gbc;
	gb_cpu_req_t cpu;
	logic [`GB_DATA_W-1:0] cpu_rdata;
	logic irq_n;
	gb_irq_src_t irq_src;
	logic [3:0] joy_din; // active low buttons
	logic [1:0] joy_p54;
	logic dl_wr;
	logic [`GB_BOOT_AW-1:0] dl_addr;
	logic [`GB_DATA_W-1:0] dl_data;
	logic [14:0] ext_addr;
	logic ext_a15;
	logic cart_rd, cart_wr;
	logic [`GB_DATA_W-1:0] cart_do;
	logic cart_oe;
	logic ncs;

	int cart_wr_cnt = 0; // cart ram write pulses seen with nCS low
	int test_cnt;
	int fail_cnt;
	bit test_bad; // set by any failing check of the running test

	gb_sys_bus dut_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .is_gbc_i(is_gbc), .cpu_i(cpu),
		.cpu_rdata_o(cpu_rdata), .irq_n_o(irq_n), .irq_src_i(irq_src),
		.joy_din_i(joy_din), .joy_p54_o(joy_p54), .dl_wr_i(dl_wr), .dl_addr_i(dl_addr),
		.dl_data_i(dl_data), .ext_addr_o(ext_addr), .ext_a15_o(ext_a15),
		.cart_rd_o(cart_rd), .cart_wr_o(cart_wr), .cart_do_i(cart_do),
		.cart_oe_i(cart_oe), .ncs_o(ncs)
	);

	// --------------------------------------------------
	// cartridge model
	// rom answers low byte xor high byte, cart ram never drives
	assign cart_do = ext_addr[7:0] ^ {ext_a15, ext_addr[14:8]};
	assign cart_oe = cart_rd & ~ext_a15;

	always @(posedge clk_sys) begin
		if (cart_wr && !ncs) cart_wr_cnt <= cart_wr_cnt + 1;
	end

	initial begin
		clk_sys = 1'b0;
		forever #clk_half clk_sys = ~clk_sys;
	end

	// --------------------------------------------------
	// bus helpers, all start and end 2 ns after an edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#drive_dly;
	endtask

	task automatic compare_byte(input logic [8*24-1:0] name, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp) begin
			$display("Error: test %0s expected %02h actual %02h", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	task automatic apply_reset(input logic [15:0] addr);
		reset_ss = 1'b1;
		cpu.addr.flat = addr;
		cpu.rd_n = 1'b1; // bus idle while in reset
		cpu.wr_n = 1'b1;
		cpu.ack = 1'b0;
		repeat (2) next_cycle();
		reset_ss = 1'b0;
	endtask

	// read held for read_lat + hold edges, then rd_n released
	task automatic cpu_read(input logic [15:0] addr, input int hold,
		output logic [7:0] rdata, output logic a15);
		cpu.addr.flat = addr;
		cpu.rd_n = 1'b0;
		for (int i = 0; i < read_lat + hold; i++) next_cycle();
		rdata = cpu_rdata; // sampled before anything moves
		a15 = ext_a15;
		cpu.rd_n = 1'b1;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] wdata,
		output int pulses);
		int wr_base;
		wr_base = cart_wr_cnt;
		cpu.addr.flat = addr;
		cpu.wdata = wdata;
		cpu.wr_n = 1'b0;
		next_cycle(); // lands on this edge
		cpu.wr_n = 1'b1;
		next_cycle(); // edge detector rearms
		pulses = cart_wr_cnt - wr_base;
	endtask

	task automatic ack_cycle(input logic [15:0] addr, output logic [7:0] vec);
		cpu.addr.flat = addr;
		cpu.ack = 1'b1;
		cpu.rd_n = 1'b0;
		for (int i = 0; i < read_lat; i++) next_cycle();
		vec = cpu_rdata;
		cpu.ack = 1'b0;
		cpu.rd_n = 1'b1;
		next_cycle(); // flag clears on the edge after ack falls
	endtask

	task automatic pulse_irq(input logic [3:0] events);
		irq_src = events;
		next_cycle(); // sampled on this edge
		irq_src = '0;
		next_cycle(); // IF bit set one edge later
	endtask

	task automatic boot_download(input logic [15:0] addr, input logic [7:0] data);
		dl_addr = addr[`GB_BOOT_AW-1:0];
		dl_data = data;
		dl_wr = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
	endtask

	task automatic wait_irq_n(input logic [8*24-1:0] name, input logic level);
		int cycles;
		cycles = 0;
		while (irq_n !== level && cycles < wait_max) begin
			next_cycle();
			cycles++;
		end
		if (irq_n !== level) begin
			$display("test %0s: irq_n_o did not reach %0b within %0d cycles", name, level,
				wait_max);
			test_bad = 1'b1;
		end
	endtask

	// nCS, cart_wr, cart_rd, irq_n, two zero bits, P15/P14
	function automatic logic [7:0] pin_status();
		return {ncs, cart_wr, cart_rd, irq_n, 2'b00, joy_p54};
	endfunction

	// --------------------------------------------------
	// one line of the test file
	task automatic run_test(input logic [8*24-1:0] name, input logic [8*8-1:0] op,
		input logic [15:0] addr, input logic [7:0] data, input logic [7:0] exp);
		logic [7:0] got;
		logic a15;
		int pulses;
		test_bad = 1'b0;
		case (op)
			"write": begin
				cpu_write(addr, data, pulses);
				compare_byte(name, exp, 8'(pulses)); // cart ram pulses
			end
			"read": begin
				cpu_read(addr, int'(data), got, a15);
				compare_byte(name, exp, got);
			end
			"a15": begin
				cpu_read(addr, int'(data), got, a15);
				compare_byte(name, exp, {7'd0, a15});
			end
			"ack": begin
				ack_cycle(addr, got);
				compare_byte(name, exp, got);
			end
			"irq": begin
				pulse_irq(data[3:0]);
				wait_irq_n(name, exp[0]);
			end
			"joy": begin
				joy_din = data[3:0];
				repeat (2) next_cycle(); // two sync stages before the edge is seen
				wait_irq_n(name, exp[0]);
			end
			"dl": boot_download(addr, data);
			"pins": compare_byte(name, exp, pin_status());
			"reset": begin
				apply_reset(addr);
				compare_byte(name, exp, pin_status());
			end
			default: begin
				$display("test %0s has an unknown operation %0s", name, op);
				test_bad = 1'b1;
			end
		endcase
		test_cnt++;
		if (test_bad) begin
			fail_cnt++;
			$display("FAIL %0s", name);
		end else begin
			$display("PASS %0s", name);
		end
	endtask

	initial begin
		int fd;
		int n;
		logic [8*128-1:0] line;
		logic [8*24-1:0] name;
		logic [8*8-1:0] op;
		logic [15:0] addr;
		logic [7:0] data;
		logic [7:0] exp;

		reset_ss = 1'b1;
		is_gbc = 1'b1; // colour model throughout
		cpu = '0;
		cpu.rd_n = 1'b1;
		cpu.wr_n = 1'b1;
		irq_src = '0;
		joy_din = 4'hf; // nothing pressed
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		test_cnt = 0;
		fail_cnt = 0;
		apply_reset(16'h0000);

		fd = $fopen("verif/gb_sys_bus_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file verif/gb_sys_bus_tests.txt");
			fail_cnt++;
		end else begin
			line = '0;
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, exp);
				if (n == 5) run_test(name, op, addr, data, exp); // comments give fewer
				line = '0;
			end
			$fclose(fd);
		end

		$display("%0d tests, %0d passed, %0d failed", test_cnt, test_cnt - fail_cnt,
			fail_cnt);
		if (fail_cnt == 0 && test_cnt > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+logic
logic/gb_bus_pkg.sv
logic/gb_irq_pkg.sv
logic/gb_addr_decode.sv
logic/gb_irq_ctrl.sv
logic/gb_work_ram.sv
logic/gb_boot_overlay.sv
logic/gb_cart_bus.sv
logic/gb_sys_bus.sv
verif/gb_sys_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the system bus testbench with verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -f src.f --top-module gb_sys_bus_tb \
	--Mdir obj_dir -o gb_sys_bus_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/gb_sys_bus_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1

// ==== verif/gb_sys_bus_tests.txt ====
# columns: test name, operation, address, data, expected, all hex
# ops: write read a15 ack irq joy dl pins reset
# the read hold cycles sit in the data column, a write expects its cart ram pulse count
wram_b0_wr      write  C000 11 00
wram_b0_rd      read   C000 00 11
svbk_1          write  FF70 01 00
wram_b1_wr      write  D010 B1 00
svbk_2          write  FF70 02 00
wram_b2_wr      write  D010 B2 00
svbk_7          write  FF70 07 00
wram_b7_wr      write  D010 B7 00
wram_b7_rd      read   D010 00 B7
svbk_0          write  FF70 00 00
wram_b0_map_rd  read   D010 00 B1
svbk_0_rd       read   FF70 00 F8
svbk_2b         write  FF70 02 00
wram_b2_rd      read   D010 00 B2
svbk_2_rd       read   FF70 00 FA
echo_hi_rd      read   F010 00 B2
echo_lo_rd      read   E000 00 11
joy_sel_wr      write  FF00 20 00
joy_sel_pins    pins   FF00 00 92
joy_rd          read   FF00 00 EF
hram_lo_wr      write  FF80 5A 00
hram_hi_wr      write  FFFE C3 00
hram_lo_rd      read   FF80 00 5A
hram_hi_rd      read   FFFE 00 C3
if_clear_rd     read   FF0F 00 E0
ie_wr           write  FFFF 05 00
ie_rd           read   FFFF 00 05
irq_vb_tm       irq    0000 05 00
if_set_rd       read   FF0F 00 E5
ack_vblank      ack    0000 00 40
if_vb_clr_rd    read   FF0F 00 E4
ack_timer       ack    0000 00 50
if_tm_clr_rd    read   FF0F 00 E0
irq_lcdc_off    irq    0000 02 01
if_lcdc_rd      read   FF0F 00 E2
if_wr           write  FF0F 00 00
joy_press       joy    0000 0E 01
if_joy_rd       read   FF0F 00 F0
ie_joy_wr       write  FFFF 10 00
ack_joypad      ack    0000 00 60
if_joy_clr_rd   read   FF0F 00 E0
joy_release     joy    0000 0F 01
dl_0042         dl     0042 3C 00
dl_0081         dl     0081 A5 00
dl_0300         dl     0300 77 00
boot_rd_0042    read   0042 00 3C
boot_rd_0081    read   0081 00 A5
boot_rd_0300    read   0300 00 77
boot_a15        a15    0042 00 01
boot_off_wr     write  FF50 01 00
cart_rd_0042    read   0042 00 42
cart_rd_0081    read   0081 00 81
cart_rd_0300    read   0300 00 03
cart_a15        a15    0042 00 00
cram_wr         write  A000 99 01
rom_rd          read   1234 00 26
cram_rd_fresh   read   A000 00 26
cram_rd_decay   read   A000 06 FF
unmapped_ff01   read   FF01 00 FF
unmapped_vram   read   8000 00 FF
reset_pins      reset  0000 00 90
rst_if_rd       read   FF0F 00 E0
rst_svbk_rd     read   FF70 00 F8
rst_boot_rd     read   0042 00 3C
